// File: logic/coherence_pkg.sv
`default_nettype none

package coherence_pkg;

    localparam int ADDR_W = 32;
    localparam int LINE_W = 128;

    typedef logic [ADDR_W-1:0] addr_t; // byte address
    typedef logic [LINE_W-1:0] line_t; // one cache line

    // controller states
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_MISS,        // probe the peers
        ST_WAIT,
        ST_WAIT2,       // peer answer or L2 fill
        ST_INVALIDATE,
        ST_REPL_DELAY,  // capture write-back line
        ST_REPLACEMENT,
        ST_WB_L2,       // peer line back to L2
        ST_DELAY        // requester drops its level here
    } cu_state_e;

endpackage

`default_nettype wire

// File: logic/request_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module request_arbiter #(
    parameter int NUM_CORES = 4,
    localparam int ID_W = $clog2(NUM_CORES)
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 capture_i,
    input  logic [NUM_CORES-1:0] miss_req_i,
    input  logic [NUM_CORES-1:0] shared_write_i,
    input  logic [NUM_CORES-1:0] replace_i,
    output logic                 any_miss_o,
    output logic                 any_inv_o,
    output logic                 any_wb_o,
    output logic [ID_W-1:0]      miss_id_o,
    output logic [ID_W-1:0]      inv_id_o,
    output logic [ID_W-1:0]      wb_id_o
);

    // lowest set bit wins, zero when the mask is empty
    function automatic logic [ID_W-1:0] lowest_index(input logic [NUM_CORES-1:0] mask);
        logic [ID_W-1:0] idx;
        idx = '0;
        for (int c = NUM_CORES - 1; c >= 0; c--) begin
            if (mask[c]) begin
                idx = ID_W'(c);
            end
        end
        return idx;
    endfunction

    logic [ID_W-1:0] miss_pick;
    logic [ID_W-1:0] inv_pick;
    logic [ID_W-1:0] wb_pick;

    assign miss_pick = lowest_index(miss_req_i);
    assign inv_pick  = lowest_index(shared_write_i);
    assign wb_pick   = lowest_index(replace_i);

    assign any_miss_o = |miss_req_i;
    assign any_inv_o  = |shared_write_i;
    assign any_wb_o   = |replace_i;

    // winners frozen once the controller leaves idle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            miss_id_o <= '0;
            inv_id_o  <= '0;
            wb_id_o   <= '0;
        end else if (capture_i) begin
            miss_id_o <= miss_pick;
            inv_id_o  <= inv_pick;
            wb_id_o   <= wb_pick;
        end
    end

endmodule

`default_nettype wire

// File: logic/snoop_response_select.sv
`timescale 1ns/1ps
`default_nettype none

module snoop_response_select #(
    parameter int NUM_CORES = 4,
    localparam int ID_W = $clog2(NUM_CORES)
) (
    input  logic                                   [NUM_CORES-1:0] snoop_ready_i,
    input  coherence_pkg::line_t [NUM_CORES-1:0]                   snoop_line_i,
    output logic                                                   snoop_hit_o,
    output coherence_pkg::line_t                                   snoop_line_o
);

    logic [ID_W-1:0] snoop_id;

    // lowest answering peer
    always_comb begin
        snoop_id = '0;
        for (int c = NUM_CORES - 1; c >= 0; c--) begin
            if (snoop_ready_i[c]) begin
                snoop_id = ID_W'(c);
            end
        end
    end

    assign snoop_hit_o  = |snoop_ready_i;
    assign snoop_line_o = snoop_hit_o ? snoop_line_i[snoop_id] : '0;

endmodule

`default_nettype wire

// File: logic/coherence_controller.sv
`timescale 1ns/1ps
`default_nettype none

module coherence_controller #(
    parameter int NUM_CORES = 4,
    localparam int ID_W = $clog2(NUM_CORES)
) (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 any_miss_i,
    input  logic                                 any_inv_i,
    input  logic                                 any_wb_i,
    input  logic [ID_W-1:0]                      miss_id_i,
    input  logic [ID_W-1:0]                      inv_id_i,
    input  logic [ID_W-1:0]                      wb_id_i,
    input  logic                                 snoop_hit_i,
    input  coherence_pkg::line_t                 snoop_line_i,
    input  logic [NUM_CORES-1:0]                 miss_is_write_i,
    input  coherence_pkg::addr_t [NUM_CORES-1:0] req_addr_i,
    input  coherence_pkg::line_t [NUM_CORES-1:0] wb_line_i,
    input  logic                                 l2_ready_i,
    input  coherence_pkg::line_t                 l2_rdata_i,
    input  logic                                 l2_exclusive_i,
    output logic                                 capture_o,
    output logic [NUM_CORES-1:0]                 reply_valid_o,
    output coherence_pkg::line_t [NUM_CORES-1:0] reply_line_o,
    output logic [NUM_CORES-1:0]                 reply_exclusive_o,
    output logic [NUM_CORES-1:0]                 probe_o,
    output coherence_pkg::addr_t [NUM_CORES-1:0] probe_addr_o,
    output logic [NUM_CORES-1:0]                 probe_invalidate_o,
    output logic                                 l2_write_o,
    output logic                                 l2_replace_o,
    output coherence_pkg::line_t                 l2_wdata_o,
    output logic                                 l2_read_o,
    output logic                                 l2_is_write_o,
    output logic                                 l2_invalidate_o,
    output coherence_pkg::addr_t                 l2_addr_o
);

    coherence_pkg::cu_state_e state;
    coherence_pkg::cu_state_e state_next;

    coherence_pkg::addr_t wb_addr_r;
    coherence_pkg::line_t wb_line_r;
    coherence_pkg::addr_t rd_addr_r;
    coherence_pkg::addr_t inv_addr_r;

    logic [NUM_CORES-1:0] miss_sel;
    logic [NUM_CORES-1:0] inv_sel;
    logic                 rd_start;
    logic                 miss_done;

    assign miss_sel  = NUM_CORES'(1) << miss_id_i;
    assign inv_sel   = NUM_CORES'(1) << inv_id_i;
    assign capture_o = (state == coherence_pkg::ST_IDLE);

    assign miss_done = snoop_hit_i || l2_ready_i; // either source ends the wait
    assign rd_start  = (state == coherence_pkg::ST_WAIT2) && !miss_done;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= coherence_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            coherence_pkg::ST_IDLE: begin
                // replacement, then invalidate, then miss
                if (any_wb_i) begin
                    state_next = coherence_pkg::ST_REPL_DELAY;
                end else if (any_inv_i) begin
                    state_next = coherence_pkg::ST_INVALIDATE;
                end else if (any_miss_i) begin
                    state_next = coherence_pkg::ST_MISS;
                end
            end
            coherence_pkg::ST_MISS:  state_next = coherence_pkg::ST_WAIT;
            coherence_pkg::ST_WAIT:  state_next = coherence_pkg::ST_WAIT2;
            coherence_pkg::ST_WAIT2: begin
                if (snoop_hit_i && miss_is_write_i[miss_id_i]) begin
                    state_next = coherence_pkg::ST_WB_L2;
                end else if (miss_done) begin
                    state_next = coherence_pkg::ST_DELAY;
                end
            end
            coherence_pkg::ST_INVALIDATE: state_next = coherence_pkg::ST_DELAY;
            coherence_pkg::ST_REPL_DELAY: state_next = coherence_pkg::ST_REPLACEMENT;
            coherence_pkg::ST_REPLACEMENT: begin
                if (l2_ready_i) begin
                    state_next = coherence_pkg::ST_DELAY;
                end
            end
            coherence_pkg::ST_WB_L2: begin
                if (l2_ready_i) begin
                    state_next = coherence_pkg::ST_IDLE;
                end
            end
            default: state_next = coherence_pkg::ST_IDLE;
        endcase
    end

    // replies to the L1s
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            reply_valid_o     <= '0;
            reply_exclusive_o <= '0;
        end else begin
            reply_valid_o     <= '0;
            reply_exclusive_o <= '0;
            if (state == coherence_pkg::ST_WAIT2 && miss_done) begin
                reply_valid_o     <= miss_sel;
                reply_exclusive_o <= (!snoop_hit_i && l2_exclusive_i) ? miss_sel : '0;
            end else if (state == coherence_pkg::ST_INVALIDATE) begin
                reply_valid_o <= inv_sel;
            end else if (state == coherence_pkg::ST_REPLACEMENT && l2_ready_i) begin
                reply_valid_o <= NUM_CORES'(1) << wb_id_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int c = 0; c < NUM_CORES; c++) begin
            if (state == coherence_pkg::ST_WAIT2 && miss_sel[c]) begin
                reply_line_o[c] <= snoop_hit_i ? snoop_line_i : l2_rdata_i; // peer line wins
            end
        end
    end

    // probes go to everyone but the requester
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            probe_o            <= '0;
            probe_invalidate_o <= '0;
        end else begin
            probe_o            <= '0;
            probe_invalidate_o <= '0;
            if (state == coherence_pkg::ST_MISS) begin
                probe_o            <= ~miss_sel;
                probe_invalidate_o <= miss_is_write_i[miss_id_i] ? ~miss_sel : '0;
            end else if (state == coherence_pkg::ST_INVALIDATE) begin
                probe_o            <= ~inv_sel;
                probe_invalidate_o <= ~inv_sel;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == coherence_pkg::ST_MISS) begin
            probe_addr_o <= {NUM_CORES{req_addr_i[miss_id_i]}};
        end else if (state == coherence_pkg::ST_INVALIDATE) begin
            probe_addr_o <= {NUM_CORES{req_addr_i[inv_id_i]}};
        end
    end

    // write-back source: evicted line or forwarded peer line
    always_ff @(posedge clk_i) begin
        if (state == coherence_pkg::ST_REPL_DELAY) begin
            wb_addr_r <= req_addr_i[wb_id_i];
            wb_line_r <= wb_line_i[wb_id_i];
        end else if (state == coherence_pkg::ST_WAIT2 && snoop_hit_i) begin
            wb_addr_r <= req_addr_i[miss_id_i];
            wb_line_r <= snoop_line_i;
        end
        if (rd_start) begin
            rd_addr_r <= req_addr_i[miss_id_i];
        end
        if (state == coherence_pkg::ST_INVALIDATE) begin
            inv_addr_r <= req_addr_i[inv_id_i];
        end
    end

    assign l2_wdata_o = wb_line_r;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            l2_write_o      <= 1'b0;
            l2_replace_o    <= 1'b0;
            l2_read_o       <= 1'b0;
            l2_is_write_o   <= 1'b0;
            l2_invalidate_o <= 1'b0;
        end else begin
            l2_write_o      <= !l2_ready_i && (state == coherence_pkg::ST_WB_L2 ||
                                               state == coherence_pkg::ST_REPLACEMENT);
            l2_replace_o    <= !l2_ready_i && state == coherence_pkg::ST_REPLACEMENT;
            l2_read_o       <= rd_start; // held until the fill comes back
            l2_is_write_o   <= rd_start && miss_is_write_i[miss_id_i];
            l2_invalidate_o <= (state == coherence_pkg::ST_INVALIDATE);
        end
    end

    always_comb begin
        if (l2_invalidate_o) begin
            l2_addr_o = inv_addr_r;
        end else if (l2_read_o) begin
            l2_addr_o = rd_addr_r;
        end else if (l2_write_o) begin
            l2_addr_o = wb_addr_r;
        end else begin
            l2_addr_o = '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/coherence_unit.sv
`timescale 1ns/1ps
`default_nettype none

module coherence_unit #(
    parameter int NUM_CORES = 4,
    localparam int ID_W = $clog2(NUM_CORES)
) (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    // L1 side
    input  logic [NUM_CORES-1:0]                 miss_req_i,
    input  logic [NUM_CORES-1:0]                 miss_is_write_i,
    input  logic [NUM_CORES-1:0]                 shared_write_i,
    input  logic [NUM_CORES-1:0]                 replace_i,
    input  coherence_pkg::addr_t [NUM_CORES-1:0] req_addr_i,
    input  coherence_pkg::line_t [NUM_CORES-1:0] wb_line_i,
    input  logic [NUM_CORES-1:0]                 snoop_ready_i,
    input  coherence_pkg::line_t [NUM_CORES-1:0] snoop_line_i,
    output logic [NUM_CORES-1:0]                 reply_valid_o,
    output coherence_pkg::line_t [NUM_CORES-1:0] reply_line_o,
    output logic [NUM_CORES-1:0]                 reply_exclusive_o,
    output logic [NUM_CORES-1:0]                 probe_o,
    output coherence_pkg::addr_t [NUM_CORES-1:0] probe_addr_o,
    output logic [NUM_CORES-1:0]                 probe_invalidate_o,
    // L2 side
    output logic                                 l2_write_o,
    output logic                                 l2_replace_o,
    output coherence_pkg::line_t                 l2_wdata_o,
    output logic                                 l2_read_o,
    output logic                                 l2_is_write_o,
    output logic                                 l2_invalidate_o,
    output coherence_pkg::addr_t                 l2_addr_o,
    input  logic                                 l2_ready_i,
    input  coherence_pkg::line_t                 l2_rdata_i,
    input  logic                                 l2_exclusive_i
);

    logic                 capture;
    logic                 any_miss;
    logic                 any_inv;
    logic                 any_wb;
    logic [ID_W-1:0]      miss_id;
    logic [ID_W-1:0]      inv_id;
    logic [ID_W-1:0]      wb_id;
    logic                 snoop_hit;
    coherence_pkg::line_t snoop_line;

    request_arbiter #(
        .NUM_CORES(NUM_CORES)
    ) u_arbiter (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .capture_i     (capture),
        .miss_req_i    (miss_req_i),
        .shared_write_i(shared_write_i),
        .replace_i     (replace_i),
        .any_miss_o    (any_miss),
        .any_inv_o     (any_inv),
        .any_wb_o      (any_wb),
        .miss_id_o     (miss_id),
        .inv_id_o      (inv_id),
        .wb_id_o       (wb_id)
    );

    snoop_response_select #(
        .NUM_CORES(NUM_CORES)
    ) u_snoop_sel (
        .snoop_ready_i(snoop_ready_i),
        .snoop_line_i (snoop_line_i),
        .snoop_hit_o  (snoop_hit),
        .snoop_line_o (snoop_line)
    );

    coherence_controller #(
        .NUM_CORES(NUM_CORES)
    ) u_ctrl (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .any_miss_i        (any_miss),
        .any_inv_i         (any_inv),
        .any_wb_i          (any_wb),
        .miss_id_i         (miss_id),
        .inv_id_i          (inv_id),
        .wb_id_i           (wb_id),
        .snoop_hit_i       (snoop_hit),
        .snoop_line_i      (snoop_line),
        .miss_is_write_i   (miss_is_write_i),
        .req_addr_i        (req_addr_i),
        .wb_line_i         (wb_line_i),
        .l2_ready_i        (l2_ready_i),
        .l2_rdata_i        (l2_rdata_i),
        .l2_exclusive_i    (l2_exclusive_i),
        .capture_o         (capture),
        .reply_valid_o     (reply_valid_o),
        .reply_line_o      (reply_line_o),
        .reply_exclusive_o (reply_exclusive_o),
        .probe_o           (probe_o),
        .probe_addr_o      (probe_addr_o),
        .probe_invalidate_o(probe_invalidate_o),
        .l2_write_o        (l2_write_o),
        .l2_replace_o      (l2_replace_o),
        .l2_wdata_o        (l2_wdata_o),
        .l2_read_o         (l2_read_o),
        .l2_is_write_o     (l2_is_write_o),
        .l2_invalidate_o   (l2_invalidate_o),
        .l2_addr_o         (l2_addr_o)
    );

endmodule

`default_nettype wire

// File: tests/coherence_unit_sva.sv
`timescale 1ns/1ps
`default_nettype none

module coherence_unit_sva #(
    parameter int NUM_CORES = 4,
    localparam int ID_W = $clog2(NUM_CORES)
) (
    input logic                     clk_i,
    input logic                     rst_i,
    input coherence_pkg::cu_state_e state_i,
    input logic [ID_W-1:0]          miss_id_i,
    input logic [ID_W-1:0]          inv_id_i,
    input logic [NUM_CORES-1:0]     reply_valid_i,
    input logic [NUM_CORES-1:0]     reply_exclusive_i,
    input logic [NUM_CORES-1:0]     probe_i,
    input logic [NUM_CORES-1:0]     probe_invalidate_i,
    input logic                     l2_write_i,
    input logic                     l2_read_i,
    input logic                     l2_replace_i,
    input logic                     l2_is_write_i,
    input logic                     l2_invalidate_i
);

    int error_count = 0;

    reply_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(reply_valid_i))
        else begin
            error_count++;
            $error("reply_valid_o has more than one bit set: %h", reply_valid_i);
        end

    l2_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(l2_write_i && l2_read_i))
        else begin
            error_count++;
            $error("l2_write_o and l2_read_o high together");
        end

    // miss probes show up in ST_WAIT and invalidate probes in ST_DELAY
    probe_skips_requester: assert property (@(posedge clk_i) disable iff (rst_i)
        (probe_i != '0) |->
            ((state_i == coherence_pkg::ST_WAIT) ? !probe_i[miss_id_i] : !probe_i[inv_id_i]))
        else begin
            error_count++;
            $error("probe sent to the core being served: %h", probe_i);
        end

    reset_quiet: assert property (@(posedge clk_i)
        rst_i |=> (state_i == coherence_pkg::ST_IDLE && reply_valid_i == '0 &&
                   reply_exclusive_i == '0 && probe_i == '0 &&
                   probe_invalidate_i == '0 && !l2_write_i && !l2_read_i &&
                   !l2_replace_i && !l2_is_write_i && !l2_invalidate_i))
        else begin
            error_count++;
            $error("controller not idle and quiet after reset");
        end

endmodule

bind coherence_controller coherence_unit_sva #(
    .NUM_CORES(NUM_CORES)
) sva0 (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .state_i           (state),
    .miss_id_i         (miss_id_i),
    .inv_id_i          (inv_id_i),
    .reply_valid_i     (reply_valid_o),
    .reply_exclusive_i (reply_exclusive_o),
    .probe_i           (probe_o),
    .probe_invalidate_i(probe_invalidate_o),
    .l2_write_i        (l2_write_o),
    .l2_read_i         (l2_read_o),
    .l2_replace_i      (l2_replace_o),
    .l2_is_write_i     (l2_is_write_o),
    .l2_invalidate_i   (l2_invalidate_o)
);

`default_nettype wire

// File: tests/coherence_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module coherence_unit_tb;

    localparam int NC = 4;

    logic clk_i;
    logic rst_i;
    logic [NC-1:0] miss_req;
    logic [NC-1:0] miss_is_write;
    logic [NC-1:0] shared_write;
    logic [NC-1:0] replace;
    logic [NC-1:0] snoop_ready;
    coherence_pkg::addr_t [NC-1:0] req_addr;
    coherence_pkg::line_t [NC-1:0] wb_line;
    coherence_pkg::line_t [NC-1:0] snoop_line;
    coherence_pkg::line_t [NC-1:0] reply_line;
    coherence_pkg::addr_t [NC-1:0] probe_addr;
    logic [NC-1:0] reply_valid;
    logic [NC-1:0] reply_excl;
    logic [NC-1:0] probe;
    logic [NC-1:0] probe_inv;
    logic l2_write;
    logic l2_replace;
    logic l2_read;
    logic l2_is_write;
    logic l2_inv;
    logic l2_ready;
    logic l2_excl;
    coherence_pkg::line_t l2_wdata;
    coherence_pkg::line_t l2_rdata;
    coherence_pkg::addr_t l2_addr;

    logic [NC-1:0] holder; // peers that keep a copy of the line
    int l2_wait;
    coherence_pkg::line_t l2_line_q;
    logic l2_excl_q;

    // what the DUT did while serving the last request
    logic [NC-1:0] seen_probe;
    logic [NC-1:0] seen_probe_inv;
    logic [NC-1:0] got_excl;
    logic seen_read;
    logic seen_read_wr;
    logic seen_write;
    logic seen_replace;
    logic seen_inv;
    coherence_pkg::addr_t seen_probe_addr;
    coherence_pkg::addr_t seen_read_addr;
    coherence_pkg::addr_t seen_write_addr;
    coherence_pkg::addr_t seen_inv_addr;
    coherence_pkg::line_t seen_wdata;
    coherence_pkg::line_t got_line;

    coherence_unit #(
        .NUM_CORES(NC)
    ) dut0 (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .miss_req_i        (miss_req),
        .miss_is_write_i   (miss_is_write),
        .shared_write_i    (shared_write),
        .replace_i         (replace),
        .req_addr_i        (req_addr),
        .wb_line_i         (wb_line),
        .snoop_ready_i     (snoop_ready),
        .snoop_line_i      (snoop_line),
        .reply_valid_o     (reply_valid),
        .reply_line_o      (reply_line),
        .reply_exclusive_o (reply_excl),
        .probe_o           (probe),
        .probe_addr_o      (probe_addr),
        .probe_invalidate_o(probe_inv),
        .l2_write_o        (l2_write),
        .l2_replace_o      (l2_replace),
        .l2_wdata_o        (l2_wdata),
        .l2_read_o         (l2_read),
        .l2_is_write_o     (l2_is_write),
        .l2_invalidate_o   (l2_inv),
        .l2_addr_o         (l2_addr),
        .l2_ready_i        (l2_ready),
        .l2_rdata_i        (l2_rdata),
        .l2_exclusive_i    (l2_excl)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin : l2_model
        coherence_pkg::line_t fill;
        fill = {$urandom, $urandom, $urandom, $urandom};
        l2_ready <= 1'b0;
        if (rst_i) begin
            l2_wait <= 0;
        end else if (l2_wait > 1) begin
            l2_wait <= l2_wait - 1;
        end else if (l2_wait == 1) begin
            l2_wait   <= 0;
            l2_ready  <= 1'b1;
            l2_rdata  <= fill;
            l2_line_q <= fill;
            l2_excl   <= fill[0];
            l2_excl_q <= fill[0];
        end else if ((l2_read || l2_write) && !l2_ready) begin
            l2_wait <= $urandom_range(5, 1);
        end
    end

    always @(posedge clk_i) begin
        snoop_ready <= probe & holder; // holders answer the cycle after a probe
    end

    task automatic fail_out(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_hex(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        assert (got === exp) else begin
            fail_out($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    // bound assertions count their failures
    always @(posedge clk_i) begin
        if (dut0.u_ctrl.sva0.error_count != 0) begin
            fail_out("a bound assertion on the controller failed");
        end
    end

    // kind 0 miss, 1 shared write, 2 replacement
    task automatic serve(input int core, input int kind);
        int cycles;
        bit replied;
        cycles = 0;
        replied = 0;
        seen_probe = '0;
        seen_probe_inv = '0;
        {seen_read, seen_read_wr, seen_write, seen_replace, seen_inv} = '0;
        while (!(replied && dut0.u_ctrl.capture_o && !l2_write && !l2_read)) begin
            @(posedge clk_i);
            cycles++;
            if (cycles > 200) begin
                fail_out($sformatf("timeout while core %0d waited for its request", core));
            end else begin
                if (probe != '0) begin
                    seen_probe      = probe;
                    seen_probe_inv  = probe_inv;
                    seen_probe_addr = probe_addr[(core + 1) % NC];
                end
                if (l2_read) begin
                    seen_read      = 1'b1;
                    seen_read_wr   = l2_is_write;
                    seen_read_addr = l2_addr;
                end
                if (l2_write) begin
                    seen_write      = 1'b1;
                    seen_replace    = l2_replace;
                    seen_wdata      = l2_wdata;
                    seen_write_addr = l2_addr;
                end
                if (l2_inv) begin
                    seen_inv      = 1'b1;
                    seen_inv_addr = l2_addr;
                end
                if (reply_valid != '0) begin
                    check_hex("reply_valid_o", reply_valid, NC'(1) << core);
                    replied  = 1;
                    got_line = reply_line[core];
                    got_excl = reply_excl;
                    case (kind)
                        0: miss_req[core] <= 1'b0;
                        1: shared_write[core] <= 1'b0;
                        default: replace[core] <= 1'b0;
                    endcase
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'h3e40));
        clk_i = 1'b0;
        rst_i = 1'b1;
        {miss_req, miss_is_write, shared_write, replace, snoop_ready, holder} = '0;
        l2_ready = 1'b0;
        l2_rdata = '0;
        l2_excl = 1'b0;
        for (int c = 0; c < NC; c++) begin
            req_addr[c]   = {$urandom} & 32'hffff_fff0;
            wb_line[c]    = {$urandom, $urandom, $urandom, $urandom};
            snoop_line[c] = {$urandom, $urandom, $urandom, $urandom};
        end
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;

        miss_req[2] <= 1'b1; // read miss with no holder
        serve(2, 0);
        check_hex("probe_o", seen_probe, 4'b1011);
        check_hex("probe_invalidate_o", seen_probe_inv, 4'b0000);
        check_hex("probe_addr_o", seen_probe_addr, req_addr[2]);
        check_hex("l2_read_o", seen_read, 1'b1);
        check_hex("l2_addr_o", seen_read_addr, req_addr[2]);
        check_hex("l2_is_write_o", seen_read_wr, 1'b0);
        check_hex("reply_line_o", got_line, l2_line_q);
        check_hex("reply_exclusive_o", got_excl, l2_excl_q ? 4'b0100 : 4'b0000);

        holder <= 4'b1000;
        miss_req[1] <= 1'b1;
        serve(1, 0);
        check_hex("reply_line_o", got_line, snoop_line[3]);
        check_hex("reply_exclusive_o", got_excl, 4'b0000);
        check_hex("l2_read_o", seen_read, 1'b0);

        holder <= 4'b0100; // write miss answered by core 2
        miss_is_write[0] <= 1'b1;
        miss_req[0] <= 1'b1;
        serve(0, 0);
        check_hex("probe_invalidate_o", seen_probe_inv, 4'b1110);
        check_hex("reply_line_o", got_line, snoop_line[2]);
        check_hex("l2_write_o", seen_write, 1'b1);
        check_hex("l2_wdata_o", seen_wdata, snoop_line[2]);
        check_hex("l2_addr_o", seen_write_addr, req_addr[0]);
        check_hex("l2_replace_o", seen_replace, 1'b0);
        holder <= 4'b0000;
        miss_is_write[0] <= 1'b0;

        shared_write[3] <= 1'b1;
        serve(3, 1);
        check_hex("probe_o", seen_probe, 4'b0111);
        check_hex("probe_invalidate_o", seen_probe_inv, 4'b0111);
        check_hex("probe_addr_o", seen_probe_addr, req_addr[3]);
        check_hex("l2_invalidate_o", seen_inv, 1'b1);
        check_hex("l2_addr_o", seen_inv_addr, req_addr[3]);

        replace[1] <= 1'b1;
        serve(1, 2);
        check_hex("l2_replace_o", seen_replace, 1'b1);
        check_hex("l2_wdata_o", seen_wdata, wb_line[1]);
        check_hex("l2_addr_o", seen_write_addr, req_addr[1]);

        // all classes at once
        miss_req[2] <= 1'b1;
        miss_req[3] <= 1'b1;
        replace[3] <= 1'b1;
        shared_write[1] <= 1'b1;
        serve(3, 2);
        check_hex("l2_wdata_o", seen_wdata, wb_line[3]);
        serve(1, 1);
        check_hex("l2_addr_o", seen_inv_addr, req_addr[1]);
        serve(2, 0);
        check_hex("l2_addr_o", seen_read_addr, req_addr[2]);
        serve(3, 0);
        check_hex("l2_addr_o", seen_read_addr, req_addr[3]);

        if (dut0.u_ctrl.sva0.error_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_out("a bound assertion on the controller failed");
        end
    end

endmodule

`default_nettype wire

// File: list.f
logic/coherence_pkg.sv
logic/request_arbiter.sv
logic/snoop_response_select.sv
logic/coherence_controller.sv
logic/coherence_unit.sv
tests/coherence_unit_sva.sv
tests/coherence_unit_tb.sv
